/* design/emb_backward.sv */
module emb_backward #(
  parameter int n_tok    = 8,
  parameter int emb_dim  = 8,
  parameter int char_num = 16
) (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       start,
  input  logic [n_tok*$clog2(char_num)-1:0]          tokens,
  input  logic [n_tok*emb_dim*emb_pkg::elem_w-1:0]   grads,
  output logic                                       busy,
  output logic                                       done,
  output emb_pkg::ram_req_t                          acc_ram,
  input  logic [emb_pkg::axil_data_w-1:0]            rdata
);

  localparam int wpr    = emb_dim / emb_pkg::data_n;
  localparam int tok_w  = $clog2(char_num);
  localparam int wcnt_w = (wpr > 1) ? $clog2(wpr) : 1;
  localparam int tcnt_w = (n_tok > 1) ? $clog2(n_tok) : 1;
  localparam int word_w = emb_pkg::data_n * emb_pkg::elem_w;
  localparam int aw     = emb_pkg::ram_addr_w;
  localparam int ew     = emb_pkg::elem_w;

  // phase 0 issues the read, phase 1 writes the sum back
  logic              phase;
  logic [wcnt_w-1:0] word_cnt;
  logic [tcnt_w-1:0] tok_cnt;
  logic              last_word;
  logic              last_tok;

  logic [tok_w-1:0]  cur_tok;
  logic [aw-1:0]     row_addr;
  logic [word_w-1:0] grad_word;
  logic [word_w-1:0] sum_word;

  // ---------------------------------------------------------------------------
  // address and gradient select
  // ---------------------------------------------------------------------------
  assign cur_tok   = tokens[tok_cnt*tok_w +: tok_w];
  assign row_addr  = aw'(cur_tok * wpr + word_cnt);
  assign grad_word = grads[(tok_cnt*wpr + word_cnt)*word_w +: word_w];

  assign last_word = (word_cnt == wcnt_w'(wpr - 1));
  assign last_tok  = (tok_cnt == tcnt_w'(n_tok - 1));

  // element-wise add, each lane wraps on its own
  always_comb begin
    for (int e = 0; e < emb_pkg::data_n; e++) begin
      sum_word[e*ew +: ew] = rdata[e*ew +: ew] + grad_word[e*ew +: ew];
    end
  end

  // same address for both halves of one read-modify-write
  always_comb begin
    acc_ram.re    = busy & ~phase;
    acc_ram.raddr = row_addr;
    acc_ram.we    = busy & phase;
    acc_ram.waddr = row_addr;
    acc_ram.wdata = sum_word;
  end

  // ---------------------------------------------------------------------------
  // sequencer
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      done     <= 1'b0;
      phase    <= 1'b0;
      word_cnt <= '0;
      tok_cnt  <= '0;
    end else begin
      done <= 1'b0;
      if (start && !busy) begin
        busy     <= 1'b1;
        phase    <= 1'b0;
        word_cnt <= '0;
        tok_cnt  <= '0;
      end else if (busy) begin
        phase <= ~phase;
        if (phase) begin
          // advance after each write
          if (last_word) begin
            word_cnt <= '0;
            if (last_tok) begin
              busy <= 1'b0;
              done <= 1'b1;
            end else begin
              tok_cnt <= tok_cnt + 1'b1;
            end
          end else begin
            word_cnt <= word_cnt + 1'b1;
          end
        end
      end
    end
  end

endmodule

/* design/emb_grad_regs.sv */
module emb_grad_regs #(
  parameter int n_tok    = 8,
  parameter int emb_dim  = 8,
  parameter int char_num = 16
) (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  emb_pkg::axil_req_t                         axil_req,
  output emb_pkg::axil_rsp_t                         axil_rsp,
  output logic                                       start,
  output logic [n_tok*$clog2(char_num)-1:0]          tokens,
  output logic [n_tok*emb_dim*emb_pkg::elem_w-1:0]   grads,
  input  logic                                       busy,
  input  logic                                       done,
  output emb_pkg::ram_req_t                          host_ram,
  input  logic [emb_pkg::axil_data_w-1:0]            rdata
);

  localparam int wpr        = emb_dim / emb_pkg::data_n;
  localparam int grad_words = n_tok * wpr;
  localparam int tbl_words  = char_num * wpr;
  localparam int tok_w      = $clog2(char_num);
  localparam int tok_iw     = (n_tok > 1) ? $clog2(n_tok) : 1;
  localparam int grad_iw    = (grad_words > 1) ? $clog2(grad_words) : 1;
  localparam int dw         = emb_pkg::axil_data_w;

  typedef enum logic [2:0] {
    rg_none, rg_ctrl, rg_status, rg_tok, rg_grad, rg_table
  } region_t;

  function automatic region_t region_of(input logic [emb_pkg::axil_addr_w-1:0] addr);
    region_t rg;
    rg = rg_none;
    if (addr == emb_pkg::ctrl_addr) rg = rg_ctrl;
    else if (addr == emb_pkg::status_addr) rg = rg_status;
    else if (32'(addr - emb_pkg::tok_base) < 4 * n_tok) rg = rg_tok;
    else if (32'(addr - emb_pkg::grad_base) < 4 * grad_words) rg = rg_grad;
    else if (32'(addr - emb_pkg::table_base) < 4 * tbl_words) rg = rg_table;
    return rg;
  endfunction

  logic [tok_w-1:0] tok_q [n_tok];
  logic [dw-1:0]    grad_q [grad_words];
  logic             done_q;

  // write channel
  logic                   wr_hs;
  region_t                wr_rg;
  logic [11:0]            aw_tok, aw_grad, aw_tbl;
  logic                   bvalid;
  emb_pkg::axil_resp_t    bresp;

  // read channel
  logic                   rd_hs;
  region_t                rd_rg;
  logic [11:0]            ar_tok, ar_grad, ar_tbl;
  logic                   rvalid, rd_wait, arready;
  emb_pkg::axil_resp_t    rresp;
  logic [dw-1:0]          rdata_q, reg_rdata;

  assign wr_hs   = axil_req.awvalid & axil_req.wvalid & ~bvalid;
  assign wr_rg   = region_of(axil_req.awaddr);
  assign aw_tok  = axil_req.awaddr - emb_pkg::tok_base;
  assign aw_grad = axil_req.awaddr - emb_pkg::grad_base;
  assign aw_tbl  = axil_req.awaddr - emb_pkg::table_base;

  assign arready = ~rvalid & ~rd_wait;
  assign rd_hs   = axil_req.arvalid & arready;
  assign rd_rg   = region_of(axil_req.araddr);
  assign ar_tok  = axil_req.araddr - emb_pkg::tok_base;
  assign ar_grad = axil_req.araddr - emb_pkg::grad_base;
  assign ar_tbl  = axil_req.araddr - emb_pkg::table_base;

  always_comb begin
    axil_rsp.awready = wr_hs;
    axil_rsp.wready  = wr_hs;
    axil_rsp.bvalid  = bvalid;
    axil_rsp.bresp   = bresp;
    axil_rsp.arready = arready;
    axil_rsp.rvalid  = rvalid;
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = rresp;
  end

  // host table port, blocked while the accumulator owns the RAM
  always_comb begin
    host_ram.we    = wr_hs & (wr_rg == rg_table) & ~busy;
    host_ram.waddr = aw_tbl[11:2];
    host_ram.wdata = axil_req.wdata;
    host_ram.re    = rd_hs & (rd_rg == rg_table) & ~busy;
    host_ram.raddr = ar_tbl[11:2];
  end

  for (genvar i = 0; i < n_tok; i++) begin : g_tok
    assign tokens[i*tok_w +: tok_w] = tok_q[i];
  end
  for (genvar w = 0; w < grad_words; w++) begin : g_grad
    assign grads[w*dw +: dw] = grad_q[w];
  end

  // ---------------------------------------------------------------------------
  // write path
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      bvalid <= 1'b0;
      bresp  <= emb_pkg::resp_okay;
      start  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      start <= wr_hs & (wr_rg == rg_ctrl) & axil_req.wdata[0] & ~busy;
      if (wr_hs) begin
        bvalid <= 1'b1;
        bresp  <= (wr_rg == rg_none || (wr_rg == rg_table && busy)) ?
                  emb_pkg::resp_slverr : emb_pkg::resp_okay;
      end else if (axil_req.bready) begin
        bvalid <= 1'b0;
      end
      // sticky until the next run starts
      if (start) done_q <= 1'b0;
      else if (done) done_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_hs && wr_rg == rg_tok && axil_req.wstrb[0]) begin
      tok_q[aw_tok[tok_iw+1:2]] <= axil_req.wdata[tok_w-1:0];
    end
    if (wr_hs && wr_rg == rg_grad) begin
      for (int b = 0; b < dw / 8; b++) begin
        if (axil_req.wstrb[b]) grad_q[aw_grad[grad_iw+1:2]][b*8 +: 8] <= axil_req.wdata[b*8 +: 8];
      end
    end
  end

  // ---------------------------------------------------------------------------
  // read path
  // ---------------------------------------------------------------------------
  always_comb begin
    case (rd_rg)
      rg_status: reg_rdata = {{(dw-2){1'b0}}, done_q, busy};
      rg_tok:    reg_rdata = dw'(tok_q[ar_tok[tok_iw+1:2]]);
      rg_grad:   reg_rdata = grad_q[ar_grad[grad_iw+1:2]];
      default:   reg_rdata = '0;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      rvalid  <= 1'b0;
      rd_wait <= 1'b0;
      rresp   <= emb_pkg::resp_okay;
    end else if (rd_wait) begin
      // RAM data is on rdata now
      rd_wait <= 1'b0;
      rvalid  <= 1'b1;
      rresp   <= emb_pkg::resp_okay;
    end else if (rd_hs) begin
      if (rd_rg == rg_table && !busy) begin
        rd_wait <= 1'b1;
      end else begin
        rvalid <= 1'b1;
        rresp  <= (rd_rg == rg_none || rd_rg == rg_table) ?
                  emb_pkg::resp_slverr : emb_pkg::resp_okay;
      end
    end else if (axil_req.rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_wait) rdata_q <= rdata;
    else if (rd_hs) rdata_q <= reg_rdata;
  end

endmodule

/* design/emb_grad_top.sv */
module emb_grad_top #(
  parameter int n_tok    = 8,
  parameter int emb_dim  = 8,
  parameter int char_num = 16
) (
  input  logic               clk,
  input  logic               rst_n,
  input  emb_pkg::axil_req_t axil_req,
  output emb_pkg::axil_rsp_t axil_rsp
);

  logic                                     start;
  logic                                     busy;
  logic                                     done;
  logic [n_tok*$clog2(char_num)-1:0]        tokens;
  logic [n_tok*emb_dim*emb_pkg::elem_w-1:0] grads;
  emb_pkg::ram_req_t                        host_ram;
  emb_pkg::ram_req_t                        acc_ram;
  logic [emb_pkg::axil_data_w-1:0]          ram_rdata;

  // ---------------------------------------------------------------------------
  // host side, AXI4-Lite registers
  // ---------------------------------------------------------------------------
  emb_grad_regs #(
    .n_tok    (n_tok),
    .emb_dim  (emb_dim),
    .char_num (char_num)
  ) emb_grad_regs_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .start    (start),
    .tokens   (tokens),
    .grads    (grads),
    .busy     (busy),
    .done     (done),
    .host_ram (host_ram),
    .rdata    (ram_rdata)
  );

  // gradient accumulation
  emb_backward #(
    .n_tok    (n_tok),
    .emb_dim  (emb_dim),
    .char_num (char_num)
  ) emb_backward_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .tokens  (tokens),
    .grads   (grads),
    .busy    (busy),
    .done    (done),
    .acc_ram (acc_ram),
    .rdata   (ram_rdata)
  );

  // shared table storage
  emb_table_ram #(
    .char_num (char_num),
    .emb_dim  (emb_dim)
  ) emb_table_ram_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .busy     (busy),
    .host_ram (host_ram),
    .acc_ram  (acc_ram),
    .rdata    (ram_rdata)
  );

endmodule

/* design/emb_pkg.sv */
package emb_pkg;

  // ---------------------------------------------------------------------------
  // element and bus sizes
  // ---------------------------------------------------------------------------
  localparam int elem_w      = 16;
  localparam int data_n      = 2;
  localparam int axil_addr_w = 12;
  localparam int axil_data_w = 32;
  // table address, wide enough for the largest table
  localparam int ram_addr_w  = 10;

  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } axil_resp_t;

  // master side of the AXI4-Lite bus
  typedef struct packed {
    logic                     awvalid;
    logic [axil_addr_w-1:0]   awaddr;
    logic                     wvalid;
    logic [axil_data_w-1:0]   wdata;
    logic [axil_data_w/8-1:0] wstrb;
    logic                     bready;
    logic                     arvalid;
    logic [axil_addr_w-1:0]   araddr;
    logic                     rready;
  } axil_req_t;

  // slave side
  typedef struct packed {
    logic                   awready;
    logic                   wready;
    logic                   bvalid;
    axil_resp_t             bresp;
    logic                   arready;
    logic                   rvalid;
    logic [axil_data_w-1:0] rdata;
    axil_resp_t             rresp;
  } axil_rsp_t;

  // one table access, read and write side by side
  typedef struct packed {
    logic                       re;
    logic [ram_addr_w-1:0]      raddr;
    logic                       we;
    logic [ram_addr_w-1:0]      waddr;
    logic [data_n*elem_w-1:0]   wdata;
  } ram_req_t;

  // ---------------------------------------------------------------------------
  // address map
  // ---------------------------------------------------------------------------
  localparam logic [axil_addr_w-1:0] ctrl_addr   = 12'h000;
  localparam logic [axil_addr_w-1:0] status_addr = 12'h004;
  localparam logic [axil_addr_w-1:0] tok_base    = 12'h100;
  localparam logic [axil_addr_w-1:0] grad_base   = 12'h200;
  localparam logic [axil_addr_w-1:0] table_base  = 12'h400;

endpackage

/* design/emb_table_ram.sv */
module emb_table_ram #(
  parameter int char_num = 16,
  parameter int emb_dim  = 8
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            busy,
  input  emb_pkg::ram_req_t               host_ram,
  input  emb_pkg::ram_req_t               acc_ram,
  output logic [emb_pkg::axil_data_w-1:0] rdata
);

  localparam int depth = char_num * emb_dim / emb_pkg::data_n;
  localparam int aw    = (depth > 1) ? $clog2(depth) : 1;

  logic [emb_pkg::axil_data_w-1:0] mem [depth];
  emb_pkg::ram_req_t               sel;

  // accumulator owns the table for the whole run
  assign sel = busy ? acc_ram : host_ram;

  always_ff @(posedge clk) begin
    if (sel.we) begin
      mem[sel.waddr[aw-1:0]] <= sel.wdata;
    end
  end

  // registered read, one cycle latency
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      rdata <= '0;
    end else if (sel.re) begin
      rdata <= mem[sel.raddr[aw-1:0]];
    end
  end

endmodule

/* list.f */
design/emb_pkg.sv
design/emb_table_ram.sv
design/emb_backward.sv
design/emb_grad_regs.sv
design/emb_grad_top.sv
tb/emb_grad_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the embedding-gradient testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir

verilator --binary --timing -Wno-fatal -f list.f --top-module emb_grad_tb -o sim_emb_grad
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_emb_grad > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$log"; then
  exit 0
fi
exit 1

/* tb/emb_grad_tb.sv */
module emb_grad_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int n_tok      = 8;
  localparam int emb_dim    = 8;
  localparam int char_num   = 16;
  localparam int wpr        = emb_dim / emb_pkg::data_n;
  localparam int grad_words = n_tok * wpr;
  localparam int tbl_words  = char_num * wpr;
  localparam int tok_w      = $clog2(char_num);
  localparam int ew         = emb_pkg::elem_w;
  localparam int run_cycles = 2 * n_tok * wpr + 2;
  // AXI accesses over all tests, status polling included
  localparam int n_access   = 520;
  localparam int limit      = (3 * run_cycles + 40 * n_access) * 2;

  typedef logic [tbl_words-1:0][emb_pkg::axil_data_w-1:0]  table_t;
  typedef logic [n_tok-1:0][tok_w-1:0]                     tok_vec_t;
  typedef logic [grad_words-1:0][emb_pkg::axil_data_w-1:0] grad_vec_t;

  logic               clk;
  logic               rst_n;
  emb_pkg::axil_req_t axil_req;
  emb_pkg::axil_rsp_t axil_rsp;

  integer    seed = 55;
  int        n_checks;
  int        n_errors;
  int        cycles;
  table_t    tbl_model;
  tok_vec_t  batch_tok;
  grad_vec_t batch_grad;

  emb_grad_top #(
    .n_tok    (n_tok),
    .emb_dim  (emb_dim),
    .char_num (char_num)
  ) emb_grad_top_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == limit) begin
      $display("timeout: no end of test after %0d cycles", limit);
      $display("** FAIL **");
      $finish;
    end
  end

  // -------------------------------------------------------------------------
  // reference model and compare tasks
  // -------------------------------------------------------------------------
  function automatic table_t expected_table(input table_t tbl, input tok_vec_t tok,
                                            input grad_vec_t grad);
    table_t      res;
    int          a;
    logic [31:0] g;
    res = tbl;
    for (int t = 0; t < n_tok; t++) begin
      for (int w = 0; w < wpr; w++) begin
        a = int'(tok[t]) * wpr + w;
        g = grad[t * wpr + w];
        // each lane wraps on its own
        for (int e = 0; e < emb_pkg::data_n; e++) begin
          res[a][e*ew +: ew] = res[a][e*ew +: ew] + g[e*ew +: ew];
        end
      end
    end
    return res;
  endfunction

  task automatic check_word(input logic [emb_pkg::axil_data_w-1:0] expected,
                            input logic [emb_pkg::axil_data_w-1:0] actual,
                            input string name);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("[ERROR] %0t ns %s: expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_resp(input emb_pkg::axil_resp_t expected,
                            input emb_pkg::axil_resp_t actual, input string name);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("[ERROR] %0t ns %s: expected %s, got %s", $time, name,
               expected.name(), actual.name());
    end
  endtask

  // -------------------------------------------------------------------------
  // AXI4-Lite master
  // -------------------------------------------------------------------------
  task automatic write_bus(input logic [11:0] addr, input logic [31:0] data,
                           output emb_pkg::axil_resp_t resp);
    int hold;
    hold = $unsigned($random(seed)) % 4;
    @(posedge clk);
    axil_req.awvalid <= 1'b1;
    axil_req.awaddr  <= addr;
    axil_req.wvalid  <= 1'b1;
    axil_req.wdata   <= data;
    axil_req.wstrb   <= 4'hf;
    @(posedge clk);
    while (!(axil_rsp.awready && axil_rsp.wready)) @(posedge clk);
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    // hold bready back a few cycles
    repeat (hold) @(posedge clk);
    axil_req.bready <= 1'b1;
    @(posedge clk);
    while (!axil_rsp.bvalid) @(posedge clk);
    resp = axil_rsp.bresp;
    axil_req.bready <= 1'b0;
  endtask

  task automatic read_bus(input logic [11:0] addr, output logic [31:0] data,
                          output emb_pkg::axil_resp_t resp);
    int hold;
    hold = $unsigned($random(seed)) % 4;
    @(posedge clk);
    axil_req.arvalid <= 1'b1;
    axil_req.araddr  <= addr;
    @(posedge clk);
    while (!axil_rsp.arready) @(posedge clk);
    axil_req.arvalid <= 1'b0;
    repeat (hold) @(posedge clk);
    axil_req.rready <= 1'b1;
    @(posedge clk);
    while (!axil_rsp.rvalid) @(posedge clk);
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    axil_req.rready <= 1'b0;
  endtask

  task automatic load_batch();
    emb_pkg::axil_resp_t resp;
    for (int i = 0; i < n_tok; i++) begin
      write_bus(emb_pkg::tok_base + 12'(4 * i), 32'(batch_tok[i]), resp);
      check_resp(emb_pkg::resp_okay, resp, $sformatf("bresp token[%0d]", i));
    end
    for (int w = 0; w < grad_words; w++) begin
      write_bus(emb_pkg::grad_base + 12'(4 * w), batch_grad[w], resp);
      check_resp(emb_pkg::resp_okay, resp, $sformatf("bresp grad[%0d]", w));
    end
  endtask

  task automatic start_run();
    emb_pkg::axil_resp_t resp;
    write_bus(emb_pkg::ctrl_addr, 32'h1, resp);
    check_resp(emb_pkg::resp_okay, resp, "bresp ctrl");
  endtask

  // poll status until the sticky done bit shows
  task automatic wait_done();
    logic [31:0]         status;
    emb_pkg::axil_resp_t resp;
    status = '0;
    while (!status[1]) begin
      read_bus(emb_pkg::status_addr, status, resp);
      check_resp(emb_pkg::resp_okay, resp, "rresp status");
    end
  endtask

  task automatic compare_table(input string what);
    logic [31:0]         data;
    emb_pkg::axil_resp_t resp;
    for (int a = 0; a < tbl_words; a++) begin
      read_bus(emb_pkg::table_base + 12'(4 * a), data, resp);
      check_resp(emb_pkg::resp_okay, resp, $sformatf("rresp table[%0d]", a));
      check_word(tbl_model[a], data, $sformatf("rdata %s table[%0d]", what, a));
    end
  endtask

  // -------------------------------------------------------------------------
  // test sequence
  // -------------------------------------------------------------------------
  initial begin
    emb_pkg::axil_resp_t resp;
    logic [31:0]         data;
    axil_req <= '0;
    rst_n    <= 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);

    // batch over rows 0..7 only, token 6 repeats token 2
    for (int i = 0; i < n_tok; i++) batch_tok[i] = tok_w'($unsigned($random(seed)) % 8);
    batch_tok[6] = batch_tok[2];
    for (int w = 0; w < grad_words; w++) batch_grad[w] = $random(seed);
    load_batch();
    for (int i = 0; i < n_tok; i++) begin
      read_bus(emb_pkg::tok_base + 12'(4 * i), data, resp);
      check_resp(emb_pkg::resp_okay, resp, "rresp token");
      check_word(32'(batch_tok[i]), data, $sformatf("rdata token[%0d]", i));
    end
    for (int w = 0; w < grad_words; w++) begin
      read_bus(emb_pkg::grad_base + 12'(4 * w), data, resp);
      check_resp(emb_pkg::resp_okay, resp, "rresp grad");
      check_word(batch_grad[w], data, $sformatf("rdata grad[%0d]", w));
    end

    // seed the table
    for (int a = 0; a < tbl_words; a++) begin
      tbl_model[a] = $random(seed);
      write_bus(emb_pkg::table_base + 12'(4 * a), tbl_model[a], resp);
      check_resp(emb_pkg::resp_okay, resp, "bresp table");
    end
    compare_table("seed");

    tbl_model = expected_table(tbl_model, batch_tok, batch_grad);
    start_run();
    wait_done();
    compare_table("run 1");

    // large gradients, lane carry must not cross
    for (int i = 0; i < n_tok; i++) batch_tok[i] = tok_w'($unsigned($random(seed)) % 16);
    batch_tok[0] = '0;
    for (int w = 0; w < grad_words; w++) batch_grad[w] = 32'hc000_8000 | $random(seed);
    batch_grad[0] = 32'h0000_0001;
    tbl_model[0] = 32'h0001_ffff;
    write_bus(emb_pkg::table_base, tbl_model[0], resp);
    check_resp(emb_pkg::resp_okay, resp, "bresp table[0]");
    load_batch();
    tbl_model = expected_table(tbl_model, batch_tok, batch_grad);
    start_run();
    wait_done();
    compare_table("run 2");

    // host table access refused during a run
    tbl_model = expected_table(tbl_model, batch_tok, batch_grad);
    start_run();
    read_bus(emb_pkg::status_addr, data, resp);
    check_word(32'h1, data, "rdata status while busy");
    read_bus(emb_pkg::table_base, data, resp);
    check_resp(emb_pkg::resp_slverr, resp, "rresp table while busy");
    write_bus(emb_pkg::table_base + 12'h4, 32'hdead_beef, resp);
    check_resp(emb_pkg::resp_slverr, resp, "bresp table while busy");
    wait_done();
    compare_table("run 3");

    // holes in the address map
    write_bus(12'h080, 32'h1234_5678, resp);
    check_resp(emb_pkg::resp_slverr, resp, "bresp unmapped");
    read_bus(12'h300, data, resp);
    check_resp(emb_pkg::resp_slverr, resp, "rresp unmapped");
    read_bus(emb_pkg::status_addr, data, resp);
    check_word(32'h2, data, "rdata status after run");

    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
